// ==== src.f ====
keypad_pkg.sv
keypad_unit.sv
key_logger.sv
event_buffer.sv
axi_key_regs.sv
keypad_top.sv
keypad_props.sv
tb_keypad.sv

// ==== run.sh ====
#!/bin/sh
# build the keypad testbench with Verilator, run it, then search the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_keypad \
    -o tb_keypad -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build error"
    exit 1
fi

./obj_dir/tb_keypad > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1

// ==== tb_keypad.sv ====
`default_nettype none

module tb_keypad
    import keypad_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int debounce_period = 8;
    localparam int scan_div        = 3;
    localparam int event_depth     = 4;
    localparam int clk_period      = 4;
    localparam int num_presses     = 13;
    localparam int press_clks      = (2 * debounce_period + 8) * scan_div;   // worst press
    localparam int watchdog_clks   = 2 * num_presses * press_clks + 1000;

    logic        clk;
    logic        rst_n;
    logic [3:0]  row_in;
    logic [3:0]  col_out;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        key_down;
    logic [1:0]  key_r;
    logic [1:0]  key_c;
    int          seq_next;  // next number the logger hands out
    integer      seed;
    int          key_rows [5] = '{0, 1, 3, 2, 3};
    int          key_cols [5] = '{0, 3, 2, 1, 3};

    keypad_top #(
        .DEBOUNCE_PERIOD (debounce_period),
        .SCAN_DIV        (scan_div),
        .EVENT_DEPTH     (event_depth)
    ) UUT (.*);

    // keypad model pulls row (3 - r) low while column (3 - c) is driven low
    always_comb begin
        row_in = 4'hf;
        if (key_down && !col_out[~key_c])
            row_in[~key_r] = 1'b0;
    end

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        step();
        while (!awready)
            step();
        check("axi write wready", 32'h1, 32'(wready));
        step();     // handshake edge
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid)
            step();
        step();     // response held back one cycle
        bready = 1'b1;
        resp   = bresp;
        step();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b0;
        step();
        while (!arready)
            step();
        step();
        arvalid = 1'b0;
        while (!rvalid)
            step();
        repeat (2) step();  // slave must hold the response meanwhile
        rready = 1'b1;
        data   = rdata;
        resp   = rresp;
        step();
        rready = 1'b0;
    endtask

    // poll STATUS until it reads the expected value
    task automatic wait_status(input logic [31:0] expected);
        logic [31:0] data;
        logic [1:0]  resp;
        data = ~expected;
        while (data != expected)
            axi_read(addr_status, data, resp);
    endtask

    task automatic expect_event(input string name, input int r, input int c);
        logic [31:0] data;
        logic [1:0]  resp;
        logic [31:0] expected;
        expected = 32'h1000 | ((seq_next % 256) << 4) | (4 * r + c);
        axi_read(addr_event, data, resp);
        check(name, 32'(resp_okay), 32'(resp));
        check(name, expected, data);
        seq_next = seq_next + 1;
    endtask

    task automatic press_key(input int r, input int c);
        int bounces;
        bounces = 1 + ($unsigned($random(seed)) % 3);
        key_r   = 2'(r);
        key_c   = 2'(c);
        repeat (bounces) begin  // contact chatter of one tick per glitch
            key_down = 1'b1;
            repeat (scan_div) step();
            key_down = 1'b0;
            repeat (scan_div) step();
        end
        key_down = 1'b1;
        repeat ((debounce_period + 8) * scan_div) step();
        key_down = 1'b0;
    endtask

    task automatic test_reset();
        logic [31:0] data;
        logic [1:0]  resp;
        check("reset col_out", 32'hf, 32'(col_out));
        axi_read(addr_ctrl, data, resp);
        check("reset ctrl", 0, data);
        axi_read(addr_status, data, resp);
        check("reset status", 0, data);
        axi_read(addr_event, data, resp);
        check("reset event valid", 0, 32'(data[12]));
        check("reset event resp", 32'(resp_okay), 32'(resp));
    endtask

    task automatic test_single_key();
        logic [31:0] data;
        logic [1:0]  resp;
        axi_write(addr_ctrl, 32'h1, resp);
        check("single ctrl resp", 32'(resp_okay), 32'(resp));
        press_key(2, 1);
        wait_status(32'd1);
        expect_event("single event", 2, 1);
        axi_read(addr_status, data, resp);
        check("single status", 0, data);
    endtask

    task automatic test_key_sequence();
        for (int i = 0; i < 5; i++) begin
            press_key(key_rows[i], key_cols[i]);
            wait_status(32'd1);
            expect_event("sequence event", key_rows[i], key_cols[i]);
        end
    endtask

    task automatic test_disabled();
        logic [31:0] data;
        logic [1:0]  resp;
        axi_write(addr_ctrl, 32'h0, resp);
        key_r    = 2'd1;
        key_c    = 2'd2;
        key_down = 1'b1;
        repeat (press_clks + 4 * scan_div) begin
            step();
            check("disabled col_out", 32'hf, 32'(col_out));
        end
        key_down = 1'b0;
        axi_read(addr_status, data, resp);
        check("disabled status", 0, data);
    endtask

    task automatic test_overflow_clear();
        logic [31:0] data;
        logic [1:0]  resp;
        axi_write(addr_ctrl, 32'h1, resp);
        for (int i = 0; i < 5; i++) begin
            press_key(key_rows[i], key_cols[i]);
            wait_status(i == 4 ? 32'h104 : i + 1);
        end
        axi_read(addr_status, data, resp);
        check("overflow status", 32'h104, data);
        for (int i = 0; i < 4; i++)
            expect_event("overflow event", key_rows[i], key_cols[i]);
        seq_next = seq_next + 1;    // dropped fifth event
        axi_write(addr_ctrl, 32'h3, resp);
        axi_read(addr_status, data, resp);
        check("clear status", 0, data);
        axi_read(addr_ctrl, data, resp);
        check("clear ctrl", 32'h1, data);
        press_key(0, 3);
        wait_status(32'd1);
        expect_event("after clear event", 0, 3);
    endtask

    task automatic test_unmapped();
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(4'hc, data, resp);
        check("unmapped read resp", 32'(resp_slverr), 32'(resp));
        axi_write(4'hc, 32'h0, resp);
        check("unmapped write resp", 32'(resp_slverr), 32'(resp));
        axi_read(addr_ctrl, data, resp);
        check("unmapped ctrl", 32'h1, data);
    endtask

    initial begin
        repeat (watchdog_clks) @(posedge clk);
        $display("timeout: tests still running after %0d clocks", watchdog_clks);
        $display("sim failed");
        $fatal(1);
    end

    initial begin
        rst_n    = 1'b0;
        awaddr   = 4'h0;
        awvalid  = 1'b0;
        wdata    = 32'd0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = 4'h0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        key_down = 1'b0;
        key_r    = 2'd0;
        key_c    = 2'd0;
        seq_next = 0;
        seed     = 32'h62c342ea;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        test_reset();
        test_single_key();
        test_key_sequence();
        test_disabled();
        test_overflow_clear();
        test_unmapped();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== keypad_props.sv ====
`default_nettype none

module keypad_props (
    input logic        clk,
    input logic        rst_n,
    input logic [3:0]  col_out,
    input logic [7:0]  key_coord,
    input logic        arready,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic [1:0]  rresp,
    input logic        bvalid,
    input logic        bready,
    input logic [1:0]  bresp
);
    timeunit 1ns;
    timeprecision 1ps;

    // at most one column driven low
    a_col_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        (col_out == 4'hf) || $onehot(~col_out))
        else $error("col_out drives more than one column low");

    a_coord_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (key_coord != 8'h00) |=> (key_coord == 8'h00))
        else $error("key_coord nonzero in two cycles in a row");

    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("read response changed before rready");

    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("write response changed before bready");

    a_ar_block: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(arready) |-> !$past(rvalid))
        else $error("arready rose while a read response was pending");

endmodule

bind keypad_top keypad_props u_props (
    .clk(clk), .rst_n(rst_n), .col_out(col_out), .key_coord(key_coord),
    .arready(arready), .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
    .bvalid(bvalid), .bready(bready), .bresp(bresp)
);

`default_nettype wire

// ==== keypad_top.sv ====
`default_nettype none

module keypad_top
    import keypad_pkg::*;
#(
    parameter int DEBOUNCE_PERIOD = 20,
    parameter int SCAN_DIV        = 100_000,
    parameter int EVENT_DEPTH     = 16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [3:0]  row_in,     // active low, pulled up
    output logic [3:0]  col_out,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    logic               scan_en;
    logic [7:0]         key_coord;
    logic               push_req;
    logic               push_gnt;
    logic [event_w-1:0] push_data;
    logic               pop_req;
    logic               pop_gnt;
    logic [event_w-1:0] pop_data;
    logic               pop_valid;
    logic [7:0]         count;
    logic               overflow;
    logic               clear;

    keypad_unit #(
        .DEBOUNCE_PERIOD (DEBOUNCE_PERIOD),
        .SCAN_DIV        (SCAN_DIV)
    ) u_keypad_unit (.*);

    key_logger u_key_logger (.*);

    event_buffer #(
        .EVENT_DEPTH (EVENT_DEPTH)
    ) u_event_buffer (.*);

    axi_key_regs u_axi_key_regs (.*);

endmodule

`default_nettype wire

// ==== axi_key_regs.sv ====
`default_nettype none

module axi_key_regs
    import keypad_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [3:0]         awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  logic [31:0]        wdata,
    input  logic               wvalid,
    output logic               wready,
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  logic               bready,
    input  logic [3:0]         araddr,
    input  logic               arvalid,
    output logic               arready,
    output logic [31:0]        rdata,
    output logic [1:0]         rresp,
    output logic               rvalid,
    input  logic               rready,
    output logic               scan_en,
    output logic               clear,
    output logic               pop_req,
    input  logic               pop_gnt,
    input  logic [event_w-1:0] pop_data,
    input  logic               pop_valid,
    input  logic [7:0]         count,
    input  logic               overflow
);

    logic idle;
    logic wr_start;
    logic rd_start;
    logic wr_fire;
    logic rd_fire;
    logic aw_mapped;

    // one transaction in flight, writes first
    assign idle      = !awready && !arready && !bvalid && !rvalid && !pop_req;
    assign wr_start  = idle && awvalid && wvalid;
    assign rd_start  = idle && arvalid && !wr_start;
    assign wr_fire   = awready && awvalid;
    assign rd_fire   = arready && arvalid;
    assign aw_mapped = (awaddr == addr_ctrl) || (awaddr == addr_status)
                       || (awaddr == addr_event);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            scan_en <= 1'b0;
            clear   <= 1'b0;
            pop_req <= 1'b0;
        end else begin
            awready <= wr_start;    // single cycle pulses
            wready  <= wr_start;
            arready <= rd_start;
            clear   <= 1'b0;

            if (wr_fire) begin
                bvalid <= 1'b1;
                if (awaddr == addr_ctrl) begin
                    scan_en <= wdata[0];
                    clear   <= wdata[1];    // w1c, self clearing
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            if (rd_fire) begin
                if (araddr == addr_event)
                    pop_req <= 1'b1;
                else
                    rvalid <= 1'b1;
            end else if (pop_req && pop_gnt) begin
                pop_req <= 1'b0;
                rvalid  <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (wr_fire)
            bresp <= aw_mapped ? resp_okay : resp_slverr;

        if (rd_fire) begin
            rresp <= resp_okay;
            case (araddr)
                addr_ctrl:   rdata <= {31'd0, scan_en};
                addr_status: rdata <= {23'd0, overflow, count};
                addr_event:  rdata <= 32'd0;    // filled in at pop_gnt
                default: begin
                    rdata <= 32'd0;
                    rresp <= resp_slverr;
                end
            endcase
        end else if (pop_req && pop_gnt) begin
            rdata <= {{(31 - event_w){1'b0}}, pop_valid, pop_data};
        end
    end

endmodule

`default_nettype wire

// ==== event_buffer.sv ====
`default_nettype none

module event_buffer
    import keypad_pkg::*;
#(
    parameter int EVENT_DEPTH = 16  // power of two
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push_req,
    input  logic [event_w-1:0] push_data,
    input  logic               pop_req,
    input  logic               clear,
    output logic               push_gnt,
    output logic               pop_gnt,
    output logic [event_w-1:0] pop_data,
    output logic               pop_valid,
    output logic [7:0]         count,
    output logic               overflow
);

    localparam int aw = $clog2(EVENT_DEPTH);
    localparam logic [aw:0] full_lvl = (aw + 1)'(EVENT_DEPTH);

    logic [event_w-1:0] mem [EVENT_DEPTH];
    logic [aw-1:0]      wr_ptr;
    logic [aw-1:0]      rd_ptr;
    logic [aw:0]        occ;
    logic               last_pop;   // 1 when pop was served last
    logic               pop_elig;
    logic               push_sel;
    logic               pop_sel;
    logic               full;
    logic               empty;

    assign full     = (occ == full_lvl);
    assign empty    = (occ == '0);
    assign pop_elig = pop_req && !pop_gnt;  // request still high during its grant cycle

    // round robin, clear wins over both
    assign push_sel = !clear && push_req && (!pop_elig || last_pop);
    assign pop_sel  = !clear && pop_elig && (!push_req || !last_pop);

    assign push_gnt = push_sel;
    assign count    = 8'(occ);

    // single port, one access per cycle
    always_ff @(posedge clk) begin
        if (push_sel && !full)
            mem[wr_ptr] <= push_data;
        else if (pop_sel)
            pop_data <= mem[rd_ptr];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occ       <= '0;
            overflow  <= 1'b0;
            last_pop  <= 1'b0;
            pop_gnt   <= 1'b0;
            pop_valid <= 1'b0;
        end else begin
            pop_gnt <= pop_sel;
            if (clear) begin
                wr_ptr   <= '0;
                rd_ptr   <= '0;
                occ      <= '0;
                overflow <= 1'b0;
            end else if (push_sel) begin
                last_pop <= 1'b0;
                if (full) begin
                    overflow <= 1'b1;   // event lost
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    occ    <= occ + 1'b1;
                end
            end else if (pop_sel) begin
                last_pop  <= 1'b1;
                pop_valid <= !empty;
                if (!empty) begin
                    rd_ptr <= rd_ptr + 1'b1;
                    occ    <= occ - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== key_logger.sv ====
`default_nettype none

module key_logger
    import keypad_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [7:0]         key_coord,
    input  logic               push_gnt,
    output logic               push_req,
    output logic [event_w-1:0] push_data
);

    logic [seq_w-1:0] seq;
    logic [1:0]       row_idx;
    logic [1:0]       col_idx;

    // index i is the one whose bit (3 - i) is low
    function automatic logic [1:0] low_pos(input logic [3:0] pat);
        logic [1:0] pos;
        pos = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (!pat[3 - i])
                pos = 2'(i);
        end
        return pos;
    endfunction

    assign row_idx = low_pos(key_coord[7:4]);
    assign col_idx = low_pos(key_coord[3:0]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            push_req <= 1'b0;
            seq      <= '0;
        end else if (push_req) begin
            if (push_gnt) begin
                push_req <= 1'b0;
                seq      <= seq + 1'b1;  // advances even when the buffer drops it
            end
        end else if (key_coord != 8'h00) begin
            push_req <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!push_req && key_coord != 8'h00)
            push_data <= {seq, row_idx, col_idx};   // index = 4r + c
    end

endmodule

`default_nettype wire

// ==== keypad_unit.sv ====
`default_nettype none

module keypad_unit #(
    parameter int DEBOUNCE_PERIOD = 20,     // in scan ticks
    parameter int SCAN_DIV        = 100_000 // clocks per tick
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       scan_en,
    input  logic [3:0] row_in,
    output logic [3:0] col_out,
    output logic [7:0] key_coord
);

    localparam logic [7:0] s_idle    = 8'b0000_0001,
                           s_press   = 8'b0000_0010,
                           s_col1    = 8'b0000_0100,
                           s_col2    = 8'b0000_1000,
                           s_col3    = 8'b0001_0000,
                           s_col4    = 8'b0010_0000,
                           s_read    = 8'b0100_0000,
                           s_release = 8'b1000_0000;

    localparam int tick_w = $clog2(SCAN_DIV + 1);
    localparam int deb_w  = $clog2(DEBOUNCE_PERIOD + 1);
    localparam logic [tick_w-1:0] tick_last = tick_w'(SCAN_DIV - 1);
    localparam logic [deb_w-1:0]  deb_last  = deb_w'(DEBOUNCE_PERIOD - 1);

    logic [tick_w-1:0] tick_cnt;
    logic              tick;
    logic [deb_w-1:0]  deb_cnt;
    logic              deb_done;
    logic [7:0]        state;
    logic [7:0]        next_state;
    logic [3:0]        row_val;
    logic [3:0]        col_val;
    logic              rows_low;
    logic              bounce;

    assign tick     = (tick_cnt == tick_last);
    assign deb_done = (deb_cnt == deb_last);
    assign rows_low = (row_in != 4'hf);
    assign bounce   = (state == s_release) && rows_low;   // key came back during release

    always_ff @(posedge clk) begin
        if (!rst_n || tick)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    always_comb begin
        next_state = s_idle;
        case (state)
            s_idle:  next_state = s_col1;
            s_col1:  next_state = rows_low ? s_press : s_col2;
            s_col2:  next_state = rows_low ? s_press : s_col3;
            s_col3:  next_state = rows_low ? s_press : s_col4;
            s_col4:  next_state = rows_low ? s_press : s_col1;
            s_press: begin
                if (!rows_low)
                    next_state = s_idle;    // glitch, start the sweep again
                else if (deb_done)
                    next_state = s_read;
                else
                    next_state = s_press;
            end
            s_read:    next_state = rows_low ? s_release : s_idle;
            s_release: next_state = (!rows_low && deb_done) ? s_idle : s_release;
            default:   next_state = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !scan_en)
            state <= s_idle;
        else if (tick)
            state <= next_state;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !scan_en)
            deb_cnt <= '0;
        else if (tick) begin
            if (next_state != state || bounce)
                deb_cnt <= '0;
            else if (state == s_press || state == s_release)
                deb_cnt <= deb_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !scan_en)
            col_out <= 4'hf;
        else if (tick) begin
            case (next_state)
                s_col1:  col_out <= 4'b0111;
                s_col2:  col_out <= 4'b1011;
                s_col3:  col_out <= 4'b1101;
                s_col4:  col_out <= 4'b1110;
                s_press, s_read, s_release:
                         col_out <= col_out;   // keep the column that hit
                default: col_out <= 4'hf;
            endcase
        end
    end

    // snapshot of the pressed key
    always_ff @(posedge clk) begin
        if (tick && state == s_read) begin
            row_val <= row_in;
            col_val <= col_out;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || !scan_en)
            key_coord <= 8'h00;
        else if (tick && state == s_release && next_state == s_idle)
            key_coord <= {row_val, col_val};  // release settled
        else
            key_coord <= 8'h00;
    end

endmodule

`default_nettype wire

// ==== keypad_pkg.sv ====
`default_nettype none

package keypad_pkg;

    // event word is {sequence, key index}
    localparam int event_w = 12;
    localparam int seq_w   = 8;     // wraps at 256

    // register byte offsets
    localparam logic [3:0] addr_ctrl   = 4'h0;
    localparam logic [3:0] addr_status = 4'h4;
    localparam logic [3:0] addr_event  = 4'h8;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire
